// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= mipsCore_tb
FILELIST ?= mipsCore.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
RUN_ARGS ?= +verilator+error+limit+100
PASS_TEXT ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== mipsCore.f ====
+incdir+source
source/mipsPkg.sv
source/regFile.sv
source/aluUnit.sv
source/memPort.sv
source/mipsControl.sv
source/dataPath.sv
source/mipsCore.sv
verif/mipsCore_chk.sv
verif/mipsCore_tb.sv

// ==== source/aluUnit.sv ====
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module aluUnit (
  input mipsPkg::aluOp_t op,
  input logic [`MIPS_DATA_W-1:0] srcA,
  input logic [`MIPS_DATA_W-1:0] srcB,
  input logic [4:0] shamt,
  output logic [`MIPS_DATA_W-1:0] result,
  output logic zero
);
  import mipsPkg::*;

  always_comb begin
    case (op)
      aluAdd: result = srcA + srcB;
      aluSub: result = srcA - srcB;
      aluAnd: result = srcA & srcB;
      aluOr: result = srcA | srcB;
      aluSlt: begin
        result = {{(`MIPS_DATA_W-1){1'b0}}, ($signed(srcA) < $signed(srcB))};
      end
      aluSll: result = srcB << shamt;
      aluLui: begin
        result = {srcB[`MIPS_DATA_W/2-1:0], {(`MIPS_DATA_W/2){1'b0}}};
      end
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);  // beq/bne after sub

endmodule

// ==== source/dataPath.sv ====
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module dataPath (
  input logic Clock,
  input logic reset,
  input mipsPkg::ctrlWord_t ctrl,
  input logic [`MIPS_DATA_W-1:0] memRdata,
  input logic memDone,
  output mipsPkg::memReq_t memReq,
  output mipsPkg::opCode_t opCode,
  output mipsPkg::funct_t funct
);
  import mipsPkg::*;

  logic [`MIPS_DATA_W-1:0] pc, ir, regA, regB, mdr, aluOut;
  logic [`MIPS_DATA_W-1:0] readA, readB, aluA, aluB, aluResult;
  logic [`MIPS_DATA_W-1:0] signImm, writeData, pcNext;
  logic [`MIPS_REG_ADDR_W-1:0] writeAddr;
  logic aluZero;
  logic branchTaken;

  assign signImm = {{(`MIPS_DATA_W-16){ir[15]}}, ir[15:0]};
  assign opCode = opCode_t'(ir[31:26]);
  assign funct = funct_t'(ir[5:0]);

  assign aluA = ctrl.aluSrcA ? regA : pc;
  always_comb begin
    case (ctrl.aluSrcB)
      2'd0: aluB = regB;
      2'd1: aluB = `MIPS_DATA_W'(4);
      2'd2: aluB = signImm;
      default: aluB = signImm << 2;  // word offset
    endcase
  end

  assign writeAddr = ctrl.regDstRd ? ir[15:11] : ir[20:16];
  assign writeData = ctrl.memToReg ? mdr : aluOut;

  assign branchTaken = (ctrl.branchEq & aluZero) | (ctrl.branchNe & ~aluZero);
  always_comb begin
    if (ctrl.pcFromJump) begin
      pcNext = {pc[`MIPS_DATA_W-1:28], ir[25:0], 2'b00};
    end else if (ctrl.branchEq | ctrl.branchNe) begin
      pcNext = aluOut;  // target from decode
    end else begin
      pcNext = aluResult;
    end
  end

  always_ff @(posedge Clock) begin
    if (reset) begin
      pc <= `MIPS_RESET_PC;
    end else if (ctrl.pcWrite | branchTaken) begin
      pc <= pcNext;
    end
  end

  always_ff @(posedge Clock) begin
    if (ctrl.irWrite && memDone) begin
      ir <= memRdata;
    end
    regA <= readA;
    regB <= readB;
    mdr <= memRdata;
    aluOut <= aluResult;
  end

  assign memReq.addr = ctrl.memAddrData ? aluOut : pc;
  assign memReq.wdata = regB;
  assign memReq.write = ctrl.memWrite;

  regFile regs (
    .Clock(Clock),
    .readAddrA(ir[25:21]),
    .readAddrB(ir[20:16]),
    .writeAddr(writeAddr),
    .writeEnable(ctrl.regWrite),
    .writeData(writeData),
    .readDataA(readA),
    .readDataB(readB)
  );

  aluUnit alu (
    .op(ctrl.aluOp),
    .srcA(aluA),
    .srcB(aluB),
    .shamt(ir[10:6]),
    .result(aluResult),
    .zero(aluZero)
  );

endmodule

// ==== source/memPort.sv ====
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module memPort (
  input logic Clock,
  input logic reset,
  input logic start,
  input mipsPkg::memReq_t reqIn,
  input logic memAck,
  input logic [`MIPS_DATA_W-1:0] memRdataIn,
  output mipsPkg::memReq_t memReq,
  output logic memReqValid,
  output logic [`MIPS_DATA_W-1:0] rdata,
  output logic done
);

  typedef enum logic [1:0] {
    portIdle,
    portReq,
    portRelease
  } portState_t;

  portState_t portState;

  always_ff @(posedge Clock) begin
    if (reset) begin
      portState <= portIdle;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      case (portState)
        portIdle: if (start) portState <= portReq;
        portReq: begin
          if (memAck) begin
            portState <= portRelease;
            done <= 1'b1;
          end
        end
        portRelease: if (!memAck) portState <= portIdle;  // wait for ack low
        default: portState <= portIdle;
      endcase
    end
  end

  always_ff @(posedge Clock) begin
    if (portState == portIdle && start) begin
      memReq <= reqIn;
    end
    if (portState == portReq && memAck) begin
      rdata <= memRdataIn;
    end
  end

  assign memReqValid = (portState == portReq);

endmodule

// ==== source/mipsControl.sv ====
`timescale 1ns/1ps

module mipsControl (
  input logic Clock,
  input logic reset,
  input mipsPkg::opCode_t opCode,
  input mipsPkg::funct_t funct,
  input logic memDone,
  output mipsPkg::ctrlWord_t ctrl,
  output logic halted
);
  import mipsPkg::*;

  ctrlState_t state;
  ctrlState_t nextState;

  always_ff @(posedge Clock) begin
    if (reset) begin
      state <= fetchReq;
    end else begin
      state <= nextState;
    end
  end

  // port name hides the state literal here
  assign halted = (state == mipsPkg::halted);

  always_comb begin
    ctrl = '0;
    ctrl.aluOp = aluAdd;
    nextState = state;
    case (state)
      fetchReq: begin
        ctrl.memStart = 1'b1;
        nextState = fetchWait;
      end
      fetchWait: begin
        ctrl.memStart = 1'b1;  // held until the port accepts
        ctrl.irWrite = 1'b1;
        ctrl.aluSrcB = 2'd1;   // pc + 4
        if (memDone) begin
          ctrl.pcWrite = 1'b1;
          nextState = decode;
        end
      end
      decode: begin
        ctrl.aluSrcB = 2'd3;   // branch target into ALUOut
        case (opCode)
          opRType: begin
            case (funct)
              fnAdd, fnSub, fnAnd, fnOr, fnSlt: nextState = rExec;
              fnSll: nextState = shiftExec;
              fnBreak: nextState = mipsPkg::halted;
              default: nextState = fetchReq;
            endcase
          end
          opJump: begin
            ctrl.pcWrite = 1'b1;
            ctrl.pcFromJump = 1'b1;
            nextState = fetchReq;
          end
          opBeq, opBne: nextState = branchCmp;
          opLui: nextState = luiExec;
          opLw, opSw: nextState = memAddr;
          default: nextState = fetchReq;
        endcase
      end
      memAddr: begin
        ctrl.aluSrcA = 1'b1;
        ctrl.aluSrcB = 2'd2;
        nextState = (opCode == opLw) ? loadWait : storeWait;
      end
      loadWait: begin
        ctrl.aluSrcA = 1'b1;   // keep the address in ALUOut
        ctrl.aluSrcB = 2'd2;
        ctrl.memStart = 1'b1;
        ctrl.memAddrData = 1'b1;
        if (memDone) begin
          nextState = loadWrite;
        end
      end
      loadWrite: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1;
        nextState = fetchReq;
      end
      storeWait: begin
        ctrl.aluSrcA = 1'b1;
        ctrl.aluSrcB = 2'd2;
        ctrl.memStart = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.memAddrData = 1'b1;
        if (memDone) begin
          nextState = fetchReq;
        end
      end
      rExec: begin
        ctrl.aluSrcA = 1'b1;
        case (funct)
          fnSub: ctrl.aluOp = aluSub;
          fnAnd: ctrl.aluOp = aluAnd;
          fnOr: ctrl.aluOp = aluOr;
          fnSlt: ctrl.aluOp = aluSlt;
          default: ctrl.aluOp = aluAdd;
        endcase
        nextState = rWrite;
      end
      shiftExec: begin
        ctrl.aluOp = aluSll;   // shamt applied to B
        nextState = rWrite;
      end
      rWrite: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDstRd = 1'b1;
        nextState = fetchReq;
      end
      branchCmp: begin
        ctrl.aluSrcA = 1'b1;
        ctrl.aluOp = aluSub;
        ctrl.branchEq = (opCode == opBeq);
        ctrl.branchNe = (opCode == opBne);
        nextState = fetchReq;
      end
      luiExec: begin
        ctrl.aluSrcB = 2'd2;
        ctrl.aluOp = aluLui;
        nextState = immWrite;
      end
      immWrite: begin
        ctrl.regWrite = 1'b1;
        nextState = fetchReq;
      end
      mipsPkg::halted: nextState = mipsPkg::halted;
      default: nextState = fetchReq;
    endcase
  end

endmodule

// ==== source/mipsCore.sv ====
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module mipsCore (
  input logic Clock,
  input logic reset,
  input logic memAck,
  input logic [`MIPS_DATA_W-1:0] memRdata,
  output mipsPkg::memReq_t memReq,
  output logic memReqValid,
  output logic halted
);

  mipsPkg::ctrlWord_t ctrl;
  mipsPkg::opCode_t opCode;
  mipsPkg::funct_t funct;
  mipsPkg::memReq_t coreReq;
  logic [`MIPS_DATA_W-1:0] portRdata;
  logic memDone;

  mipsControl control (
    .Clock(Clock),
    .reset(reset),
    .opCode(opCode),
    .funct(funct),
    .memDone(memDone),
    .ctrl(ctrl),
    .halted(halted)
  );

  dataPath path (
    .Clock(Clock),
    .reset(reset),
    .ctrl(ctrl),
    .memRdata(portRdata),
    .memDone(memDone),
    .memReq(coreReq),
    .opCode(opCode),
    .funct(funct)
  );

  memPort port (
    .Clock(Clock),
    .reset(reset),
    .start(ctrl.memStart),
    .reqIn(coreReq),
    .memAck(memAck),
    .memRdataIn(memRdata),
    .memReq(memReq),
    .memReqValid(memReqValid),
    .rdata(portRdata),
    .done(memDone)
  );

endmodule

// ==== source/mipsCore_cfg.svh ====
`ifndef MIPS_CORE_CFG_SVH
`define MIPS_CORE_CFG_SVH

// datapath and address width
`define MIPS_DATA_W 32

// general register file
`define MIPS_REG_CNT 32
`define MIPS_REG_ADDR_W 5

// first fetch address
`define MIPS_RESET_PC 32'h0000_0000

`endif

// ==== source/mipsPkg.sv ====
`include "mipsCore_cfg.svh"

package mipsPkg;

  typedef enum logic [4:0] {
    fetchReq,
    fetchWait,
    decode,
    memAddr,
    loadWait,
    loadWrite,
    storeWait,
    rExec,
    rWrite,
    shiftExec,
    branchCmp,
    luiExec,
    immWrite,
    halted
  } ctrlState_t;

  typedef enum logic [5:0] {
    opRType = 6'h00,
    opJump  = 6'h02,
    opBeq   = 6'h04,
    opBne   = 6'h05,
    opLui   = 6'h0f,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opCode_t;

  typedef enum logic [5:0] {
    fnSll   = 6'h00,
    fnBreak = 6'h0d,
    fnAdd   = 6'h20,
    fnSub   = 6'h22,
    fnAnd   = 6'h24,
    fnOr    = 6'h25,
    fnSlt   = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluSll,
    aluLui
  } aluOp_t;

  typedef struct packed {
    logic pcWrite;
    logic pcFromJump;
    logic branchEq;
    logic branchNe;
    logic irWrite;
    logic regWrite;
    logic regDstRd;     // rd instead of rt
    logic memToReg;
    logic aluSrcA;      // 0 pc, 1 reg A
    logic [1:0] aluSrcB;  // B, four, imm, imm << 2
    aluOp_t aluOp;
    logic memStart;
    logic memWrite;
    logic memAddrData;  // address from ALUOut
  } ctrlWord_t;

  typedef struct packed {
    logic [`MIPS_DATA_W-1:0] addr;
    logic [`MIPS_DATA_W-1:0] wdata;
    logic write;
  } memReq_t;

endpackage

// ==== source/regFile.sv ====
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module regFile (
  input logic Clock,
  input logic [`MIPS_REG_ADDR_W-1:0] readAddrA,
  input logic [`MIPS_REG_ADDR_W-1:0] readAddrB,
  input logic [`MIPS_REG_ADDR_W-1:0] writeAddr,
  input logic writeEnable,
  input logic [`MIPS_DATA_W-1:0] writeData,
  output logic [`MIPS_DATA_W-1:0] readDataA,
  output logic [`MIPS_DATA_W-1:0] readDataB
);

  logic [`MIPS_DATA_W-1:0] regs [`MIPS_REG_CNT];

  always_ff @(posedge Clock) begin
    if (writeEnable && writeAddr != '0) begin  // $zero stays zero
      regs[writeAddr] <= writeData;
    end
  end

  assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== verif/mipsCore_chk.sv ====
`timescale 1ns/1ps

module mipsCore_chk (
  input logic Clock,
  input logic reset,
  input mipsPkg::memReq_t memReq,
  input logic memReqValid,
  input logic memAck,
  input logic halted
);

  int assertFails = 0;  // summed into the testbench error count

  reqHeld: assert property (@(posedge Clock) disable iff (reset)
      memReqValid |=> (!memReqValid || $stable(memReq)))
    else begin
      assertFails++;
      $error("memReq changed while memReqValid was high");
    end

  // new request only after ack is low
  noRiseOnAck: assert property (@(posedge Clock) disable iff (reset)
      $rose(memReqValid) |-> !$past(memAck))
    else begin
      assertFails++;
      $error("memReqValid rose while memAck was high");
    end

  haltSticky: assert property (@(posedge Clock) disable iff (reset)
      halted |=> halted)
    else begin
      assertFails++;
      $error("halted dropped without reset");
    end

endmodule

bind mipsCore mipsCore_chk chk (
  .Clock(Clock),
  .reset(reset),
  .memReq(memReq),
  .memReqValid(memReqValid),
  .memAck(memAck),
  .halted(halted)
);

// ==== verif/mipsCore_tb.sv ====
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module mipsCore_tb;
  import mipsPkg::*;

  localparam int reqTimeout = 200;   // cycles without any request
  localparam int ackDropTimeout = 20;
  localparam int maxRequests = 1000;
  localparam int quietCycles = 50;

  logic Clock;
  logic reset;
  logic memAck;
  logic [`MIPS_DATA_W-1:0] memRdata;
  memReq_t memReq;
  logic memReqValid;
  logic halted;

  logic [31:0] testData [0:511];     // kind, address, value triples
  logic [31:0] memory [logic [31:0]];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  int errorCount;
  int checkCount;
  int storeCount;
  int expectedStores;
  bit runAborted;
  bit firstRequest;

  mipsCore dut (
    .Clock(Clock),
    .reset(reset),
    .memAck(memAck),
    .memRdata(memRdata),
    .memReq(memReq),
    .memReqValid(memReqValid),
    .halted(halted)
  );

  initial begin
    Clock = 1'b0;
    forever #10 Clock = ~Clock;
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic reportError(input string what);
    errorCount++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  function automatic logic [31:0] readWord(input logic [31:0] addr);
    if (memory.exists(addr)) begin
      return memory[addr];
    end
    return addr ^ 32'h5a5a_a5a5;     // unloaded words
  endfunction

  task automatic loadTestData();
    logic [8:0] pos;
    bit ended;
    pos = '0;
    ended = 1'b0;
    $readmemh("verif/mipsCore_testdata.txt", testData);
    while (!ended) begin
      if (pos > 9'd507) begin
        reportError("testdata has no end record");
        runAborted = 1'b1;
        ended = 1'b1;
      end else begin
        case (testData[pos])
          32'h1: memory[testData[pos + 9'd1]] = testData[pos + 9'd2];
          32'h2: begin
            expAddr.push_back(testData[pos + 9'd1]);
            expData.push_back(testData[pos + 9'd2]);
          end
          32'hf: begin
            expectedStores = int'(testData[pos + 9'd2]);
            ended = 1'b1;
          end
          default: begin
            reportError($sformatf("testdata record %0d has an unknown kind", pos / 3));
            runAborted = 1'b1;
            ended = 1'b1;
          end
        endcase
      end
      pos = pos + 9'd3;
    end
    checkValue("expected store count", expAddr.size(), expectedStores);
  endtask

  task automatic recordStore(input logic [31:0] addr, input logic [31:0] data);
    storeCount++;
    memory[addr] = data;
    if (expAddr.size() == 0) begin
      reportError($sformatf("unexpected store of %h to address %h", data, addr));
    end else begin
      checkValue("store address", addr, expAddr.pop_front());
      checkValue("store data", data, expData.pop_front());
    end
  endtask

  task automatic answerRequest();
    memReq_t req;
    int delay;
    int waited;
    req = memReq;
    if (firstRequest) begin
      checkValue("first request address", req.addr, `MIPS_RESET_PC);
      checkValue("first request write", 32'(req.write), 32'd0);
      firstRequest = 1'b0;
    end
    delay = int'($urandom_range(4, 0));
    repeat (delay) @(negedge Clock);
    if (req.write) begin
      recordStore(req.addr, req.wdata);
    end else begin
      memRdata = readWord(req.addr);
    end
    memAck = 1'b1;
    waited = 0;
    do begin
      @(negedge Clock);
      waited++;
    end while (memReqValid && waited < ackDropTimeout);
    if (memReqValid) begin
      reportError("memReqValid stayed high after memAck");
      runAborted = 1'b1;
    end
    memAck = 1'b0;
  endtask

  task automatic serveUntilHalt();
    int idle;
    int served;
    bit finished;
    served = 0;
    finished = 1'b0;
    while (!finished) begin
      idle = 0;
      while (!memReqValid && !halted && idle < reqTimeout) begin
        @(negedge Clock);
        idle++;
      end
      if (halted) begin
        finished = 1'b1;
      end else if (!memReqValid) begin
        reportError($sformatf("no memory request and no halt for %0d cycles", reqTimeout));
        runAborted = 1'b1;
        finished = 1'b1;
      end else begin
        answerRequest();
        served++;
        if (runAborted) begin
          finished = 1'b1;
        end else if (served >= maxRequests) begin
          reportError($sformatf("core did not halt within %0d requests", maxRequests));
          runAborted = 1'b1;
          finished = 1'b1;
        end
      end
    end
  endtask

  task automatic checkQuietAfterHalt();
    int cycle;
    bit seen;
    seen = 1'b0;
    for (cycle = 0; cycle < quietCycles; cycle++) begin
      @(negedge Clock);
      if (memReqValid && !seen) begin
        reportError("memory request after the core halted");
        seen = 1'b1;
      end
    end
    checkValue("halted", 32'(halted), 32'd1);
  endtask

  initial begin
    reset = 1'b1;
    memAck = 1'b0;
    memRdata = '0;
    errorCount = 0;
    checkCount = 0;
    storeCount = 0;
    expectedStores = 0;
    runAborted = 1'b0;
    firstRequest = 1'b1;
    void'($urandom(32'h6caf9e03));
    loadTestData();
    repeat (3) begin
      @(negedge Clock);
      checkValue("memReqValid during reset", 32'(memReqValid), 32'd0);
    end
    reset = 1'b0;
    if (!runAborted) begin
      serveUntilHalt();
    end
    if (!runAborted) begin
      checkQuietAfterHalt();
      checkValue("store count", storeCount, expectedStores);
    end
    errorCount += dut.chk.assertFails;
    $display("checks %0d, errors %0d, stores %0d of %0d",
             checkCount, errorCount, storeCount, expectedStores);
    if (errorCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== verif/mipsCore_testdata.txt ====
// columns: kind address value, all hex
// kind 1 loads a memory word, kind 2 expects a store in order, kind f ends (value = store count)
1 00000000 3c011234 // lui $1, 0x1234
1 00000004 8c020100 // lw $2, 0x100($0)
1 00000008 8c030104 // lw $3, 0x104($0)
1 0000000c 00222020 // add $4, $1, $2
1 00000010 ac040200 // sw $4, 0x200($0)
1 00000014 00622822 // sub $5, $3, $2
1 00000018 ac050204 // sw $5, 0x204($0)
1 0000001c 00623024 // and $6, $3, $2
1 00000020 ac060208 // sw $6, 0x208($0)
1 00000024 00623825 // or $7, $3, $2
1 00000028 ac07020c // sw $7, 0x20c($0)
1 0000002c 0043402a // slt $8, $2, $3
1 00000030 00034900 // sll $9, $3, 4
1 00000034 ac080210 // sw $8, 0x210($0)
1 00000038 ac090214 // sw $9, 0x214($0)
1 0000003c 8c0b0200 // lw $11, 0x200($0)
1 00000040 8c0c0204 // lw $12, 0x204($0)
1 00000044 016c6822 // sub $13, $11, $12
1 00000048 ac0d0218 // sw $13, 0x218($0)
1 0000004c 10430001 // beq $2, $3 not taken
1 00000050 ac02021c // sw $2, 0x21c($0)
1 00000054 108b0001 // beq $4, $11 taken
1 00000058 ac0302f0 // skipped
1 0000005c 14430001 // bne $2, $3 taken
1 00000060 ac0302f4 // skipped
1 00000064 148b0001 // bne $4, $11 not taken
1 00000068 ac030220 // sw $3, 0x220($0)
1 0000006c 0800001d // j 0x74
1 00000070 ac0302f8 // skipped
1 00000074 3c0e8000 // lui $14, 0x8000
1 00000078 01c2782a // slt $15, $14, $2, signed
1 0000007c ac0f0224 // sw $15, 0x224($0)
1 00000080 ac0e0228 // sw $14, 0x228($0)
1 00000084 ad22ffc0 // sw $2, -64($9)
1 00000088 0000000d // break
1 00000100 000000f5
1 00000104 00000a3c
2 00000200 123400f5
2 00000204 00000947
2 00000208 00000034
2 0000020c 00000afd
2 00000210 00000001
2 00000214 0000a3c0
2 00000218 1233f7ae
2 0000021c 000000f5
2 00000220 00000a3c
2 00000224 00000001
2 00000228 80000000
2 0000a380 000000f5
f 00000000 0000000c
